//--- common/opl_pkg.sv
// Shared definitions for the FM register front end.
// Widths, register map constants, update kinds and the slot layout rule.
// Import with a wildcard in the module header.

package opl_pkg;

    typedef logic [7:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;
    typedef logic [4:0] slot_t;
    typedef logic [3:0] chan_t;
    typedef logic [9:0] fnum_t;
    typedef logic [2:0] block_t;
    typedef logic [3:0] rate_t;
    typedef logic [5:0] tl_t;
    typedef logic [7:0] timer_val_t;

    localparam int SLOT_COUNT = 18;
    localparam int CHAN_COUNT = 9;

    // global control registers
    localparam reg_addr_t REG_CLKA   = 8'h02;
    localparam reg_addr_t REG_CLKB   = 8'h03;
    localparam reg_addr_t REG_TIMER  = 8'h04;
    localparam reg_addr_t REG_MODE   = 8'h05;
    localparam reg_addr_t REG_GLOBAL = 8'hBD;

    typedef enum logic [3:0] {
        UPD_NONE,
        UPD_MULT,
        UPD_KSL_TL,
        UPD_AR_DR,
        UPD_SL_RR,
        UPD_WAV,
        UPD_FNUM_LO,
        UPD_FNUM_HI,
        UPD_FB_CON
    } upd_kind_t;

    // slot index of an operator register offset
    function automatic slot_t op_slot(input logic [1:0] group, input logic [2:0] sub);
        return slot_t'(5'(group) * 5'd6 + 5'(sub));
    endfunction

    // channel that owns a slot, sub 0..2 op1 and 3..5 op2
    function automatic chan_t slot_chan(input slot_t slot);
        logic [1:0] group;
        logic [2:0] sub;
        group = 2'(slot / 5'd6);
        sub   = 3'(slot % 5'd6);
        if (sub >= 3'd3)
            sub = sub - 3'd3;
        return chan_t'(4'(group) * 4'd3 + 4'(sub));
    endfunction

endpackage

//--- common/opl_ifs.sv
// Internal links between the register decoder and its consumers.
// opl_wr_if carries one-clock parameter updates to the slot storage,
// opl_tmr_if carries timer presets and control levels to the timers.
`timescale 1ns/1ps

interface opl_wr_if
    import opl_pkg::*;
();
    upd_kind_t kind;
    slot_t     slot;
    chan_t     chan;
    reg_data_t data;
    logic      wave_mode;

    modport decode (output kind, output slot, output chan, output data, output wave_mode);
    modport regs   (input kind, input slot, input chan, input data, input wave_mode);
endinterface

interface opl_tmr_if
    import opl_pkg::*;
();
    timer_val_t value_a;
    timer_val_t value_b;
    logic       load_a;
    logic       load_b;
    logic       mask_a;
    logic       mask_b;
    // one clock wide
    logic       clr_flags;

    modport decode (output value_a, value_b, load_a, load_b, mask_a, mask_b, clr_flags);
    modport timer  (input value_a, value_b, load_a, load_b, mask_a, mask_b, clr_flags);
endinterface

//--- mmr/opl_mmr_decode.sv
// APB slave for the two-port register interface.
// Address port writes select a register, data port writes are decoded into
// operator/channel updates or global and timer control. Reads return status.
`timescale 1ns/1ps

module opl_mmr_decode
    import opl_pkg::*;
#(
    parameter int OPL_TYPE = 2
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  logic [2:0] paddr,
    input  reg_data_t  pwdata,
    output reg_data_t  prdata,
    output logic       pready,
    output logic       pslverr,
    input  logic       irq,
    input  logic       flag_a,
    input  logic       flag_b,
    opl_wr_if.decode   wr,
    opl_tmr_if.decode  tmr
);
    reg_addr_t sel_reg;
    logic      wave_mode;
    logic      wr_access;
    logic      op_ok;
    logic      ch_ok;
    upd_kind_t kind_nxt;
    slot_t     slot_nxt;
    chan_t     chan_nxt;

    // zero wait states, no error responses
    assign pready  = 1'b1;
    assign pslverr = 1'b0;
    assign prdata  = {irq, flag_a, flag_b, 5'd0};

    assign wr_access    = psel && penable && pwrite;
    assign wr.wave_mode = wave_mode;

    // operator offsets: group in [4:3], sub in [2:0]
    assign op_ok = (sel_reg[2:0] <= 3'd5) && (sel_reg[4:3] != 2'd3);
    assign ch_ok = sel_reg[3:0] <= 4'd8;

    always_comb begin
        kind_nxt = UPD_NONE;
        slot_nxt = op_slot(sel_reg[4:3], sel_reg[2:0]);
        chan_nxt = chan_t'(sel_reg[3:0]);
        if (op_ok) begin
            case (sel_reg[7:5])
                3'd1: kind_nxt = UPD_MULT;
                3'd2: kind_nxt = UPD_KSL_TL;
                3'd3: kind_nxt = UPD_AR_DR;
                3'd4: kind_nxt = UPD_SL_RR;
                // waveform select only on OPL2 with mode bit 5 set
                3'd7: if (OPL_TYPE != 1 && wave_mode) kind_nxt = UPD_WAV;
                default: ;
            endcase
        end
        // 0xBD has low nibble D, so it never lands here
        if (ch_ok) begin
            case (sel_reg[7:4])
                4'hA: kind_nxt = UPD_FNUM_LO;
                4'hB: kind_nxt = UPD_FNUM_HI;
                4'hC: kind_nxt = UPD_FB_CON;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_reg       <= '0;
            wave_mode     <= 1'b0;
            wr.kind       <= UPD_NONE;
            tmr.value_a   <= '0;
            tmr.value_b   <= '0;
            tmr.load_a    <= 1'b0;
            tmr.load_b    <= 1'b0;
            tmr.mask_a    <= 1'b0;
            tmr.mask_b    <= 1'b0;
            tmr.clr_flags <= 1'b0;
        end else begin
            // pulses last one clock
            wr.kind       <= UPD_NONE;
            tmr.clr_flags <= 1'b0;
            if (wr_access) begin
                if (!paddr[2]) begin
                    sel_reg <= pwdata;
                end else begin
                    wr.kind <= kind_nxt;
                    case (sel_reg)
                        REG_CLKA:   tmr.value_a <= pwdata;
                        REG_CLKB:   tmr.value_b <= pwdata;
                        REG_TIMER: begin
                            tmr.clr_flags <= pwdata[7];
                            tmr.mask_a    <= pwdata[6];
                            tmr.mask_b    <= pwdata[5];
                            tmr.load_b    <= pwdata[1];
                            tmr.load_a    <= pwdata[0];
                        end
                        REG_MODE:   wave_mode  <= pwdata[5];
                        default: ;
                    endcase
                end
            end
        end
    end

    // update payload, qualified by wr.kind
    always_ff @(posedge clk) begin
        if (wr_access && paddr[2]) begin
            wr.slot <= slot_nxt;
            wr.chan <= chan_nxt;
            wr.data <= pwdata;
        end
    end

endmodule

//--- mmr/opl_slot_regs.sv
// Operator and channel parameter storage with slot sequencer.
// Updates from the decoder write the arrays; each cen step moves to the next
// slot and registers its operator fields and its channel's fields together.
`timescale 1ns/1ps

module opl_slot_regs
    import opl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    opl_wr_if.regs     wr,
    output slot_t      slot,
    output logic [3:0] mul,
    output tl_t        tl,
    output logic [1:0] ksl,
    output rate_t      ar,
    output rate_t      dr,
    output rate_t      sl,
    output rate_t      rr,
    output logic [1:0] wavsel,
    output fnum_t      fnum,
    output block_t     block,
    output logic       keyon,
    output logic [2:0] fb,
    output logic       con
);
    // per slot
    logic [3:0] mul_m    [SLOT_COUNT];
    tl_t        tl_m     [SLOT_COUNT];
    logic [1:0] ksl_m    [SLOT_COUNT];
    rate_t      ar_m     [SLOT_COUNT];
    rate_t      dr_m     [SLOT_COUNT];
    rate_t      sl_m     [SLOT_COUNT];
    rate_t      rr_m     [SLOT_COUNT];
    logic [1:0] wav_m    [SLOT_COUNT];
    // per channel
    fnum_t      fnum_m   [CHAN_COUNT];
    block_t     block_m  [CHAN_COUNT];
    logic       keyon_m  [CHAN_COUNT];
    logic [2:0] fb_m     [CHAN_COUNT];
    logic       con_m    [CHAN_COUNT];

    slot_t slot_nxt;
    chan_t chan_nxt;

    assign slot_nxt = (slot == slot_t'(SLOT_COUNT - 1)) ? '0 : slot + 1'b1;
    assign chan_nxt = slot_chan(slot_nxt);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < SLOT_COUNT; i++) begin
                mul_m[i] <= '0;
                tl_m[i]  <= '0;
                ksl_m[i] <= '0;
                ar_m[i]  <= '0;
                dr_m[i]  <= '0;
                sl_m[i]  <= '0;
                rr_m[i]  <= '0;
                wav_m[i] <= '0;
            end
            for (int i = 0; i < CHAN_COUNT; i++) begin
                fnum_m[i]  <= '0;
                block_m[i] <= '0;
                keyon_m[i] <= 1'b0;
                fb_m[i]    <= '0;
                con_m[i]   <= 1'b0;
            end
        end else begin
            case (wr.kind)
                UPD_MULT:   mul_m[wr.slot] <= wr.data[3:0];
                UPD_KSL_TL: {ksl_m[wr.slot], tl_m[wr.slot]} <= wr.data;
                UPD_AR_DR:  {ar_m[wr.slot], dr_m[wr.slot]} <= wr.data;
                UPD_SL_RR:  {sl_m[wr.slot], rr_m[wr.slot]} <= wr.data;
                UPD_WAV:    if (wr.wave_mode) wav_m[wr.slot] <= wr.data[1:0];
                UPD_FNUM_LO: fnum_m[wr.chan][7:0] <= wr.data;
                // keyon, block and the two fnum msbs
                UPD_FNUM_HI: begin
                    keyon_m[wr.chan]     <= wr.data[5];
                    block_m[wr.chan]     <= wr.data[4:2];
                    fnum_m[wr.chan][9:8] <= wr.data[1:0];
                end
                UPD_FB_CON: {fb_m[wr.chan], con_m[wr.chan]} <= wr.data[3:0];
                default: ;
            endcase
        end
    end

    // slot readout, all fields change on the same cen edge
    always_ff @(posedge clk) begin
        if (rst) begin
            slot   <= '0;
            mul    <= '0;
            tl     <= '0;
            ksl    <= '0;
            ar     <= '0;
            dr     <= '0;
            sl     <= '0;
            rr     <= '0;
            wavsel <= '0;
            fnum   <= '0;
            block  <= '0;
            keyon  <= 1'b0;
            fb     <= '0;
            con    <= 1'b0;
        end else if (cen) begin
            slot   <= slot_nxt;
            mul    <= mul_m[slot_nxt];
            tl     <= tl_m[slot_nxt];
            ksl    <= ksl_m[slot_nxt];
            ar     <= ar_m[slot_nxt];
            dr     <= dr_m[slot_nxt];
            sl     <= sl_m[slot_nxt];
            rr     <= rr_m[slot_nxt];
            wavsel <= wav_m[slot_nxt];
            fnum   <= fnum_m[chan_nxt];
            block  <= block_m[chan_nxt];
            keyon  <= keyon_m[chan_nxt];
            fb     <= fb_m[chan_nxt];
            con    <= con_m[chan_nxt];
        end
    end

endmodule

//--- design/opl_timers.sv
// Programmable timers A and B.
// A loaded timer counts up from its preset once every DIV cen pulses and
// sets its flag on the tick after 255, reloading the preset. irq is the OR.
`timescale 1ns/1ps

module opl_timers
    import opl_pkg::*;
#(
    parameter int TIMER_A_DIV = 2,
    parameter int TIMER_B_DIV = 8
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    opl_tmr_if.timer   tmr,
    output logic       flag_a,
    output logic       flag_b,
    output logic       irq
);
    timer_val_t preset [2];
    logic [1:0] load;
    logic [1:0] mask;

    assign preset[0] = tmr.value_a;
    assign preset[1] = tmr.value_b;
    assign load      = {tmr.load_b, tmr.load_a};
    assign mask      = {tmr.mask_b, tmr.mask_a};

    for (genvar i = 0; i < 2; i++) begin : g_timer
        localparam int DIV = (i == 0) ? TIMER_A_DIV : TIMER_B_DIV;
        localparam int PW  = (DIV > 1) ? $clog2(DIV) : 1;

        logic [PW-1:0] pre;
        timer_val_t    cnt;
        logic          tick;
        logic          flag;

        // prescaler wraps after DIV cen pulses
        assign tick = cen && (pre == PW'(DIV - 1));

        always_ff @(posedge clk) begin
            if (rst) begin
                pre  <= '0;
                cnt  <= '0;
                flag <= 1'b0;
            end else begin
                if (!load[i]) begin
                    // stopped, hold the preset
                    pre <= '0;
                    cnt <= preset[i];
                end else if (cen) begin
                    pre <= tick ? '0 : pre + 1'b1;
                    if (tick)
                        cnt <= (cnt == 8'hFF) ? preset[i] : cnt + 1'b1;
                end
                if (tmr.clr_flags)
                    flag <= 1'b0;
                else if (load[i] && tick && cnt == 8'hFF && !mask[i])
                    flag <= 1'b1;
            end
        end
    end

    assign flag_a = g_timer[0].flag;
    assign flag_b = g_timer[1].flag;
    assign irq    = flag_a || flag_b;

endmodule

//--- design/opl_top.sv
// Register front end of a two-operator FM sound chip.
// Host access over APB (address port at 0, data port at 4), slot parameter
// readout stepped by cen, and timers A/B with interrupt.
`timescale 1ns/1ps

module opl_top
    import opl_pkg::*;
#(
    parameter int OPL_TYPE    = 2,
    parameter int TIMER_A_DIV = 2,
    parameter int TIMER_B_DIV = 8
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    // APB slave
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  logic [2:0] paddr,
    input  reg_data_t  pwdata,
    output reg_data_t  prdata,
    output logic       pready,
    output logic       pslverr,
    // current slot parameters
    output slot_t      slot,
    output logic [3:0] mul,
    output tl_t        tl,
    output logic [1:0] ksl,
    output rate_t      ar,
    output rate_t      dr,
    output rate_t      sl,
    output rate_t      rr,
    output logic [1:0] wavsel,
    output fnum_t      fnum,
    output block_t     block,
    output logic       keyon,
    output logic [2:0] fb,
    output logic       con,
    output logic       irq
);
    logic flag_a;
    logic flag_b;

    opl_wr_if  wr_if ();
    opl_tmr_if tmr_if ();

    opl_mmr_decode #(.OPL_TYPE(OPL_TYPE)) u_decode (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .irq     (irq),
        .flag_a  (flag_a),
        .flag_b  (flag_b),
        .wr      (wr_if.decode),
        .tmr     (tmr_if.decode)
    );

    opl_slot_regs u_regs (
        .clk    (clk),
        .rst    (rst),
        .cen    (cen),
        .wr     (wr_if.regs),
        .slot   (slot),
        .mul    (mul),
        .tl     (tl),
        .ksl    (ksl),
        .ar     (ar),
        .dr     (dr),
        .sl     (sl),
        .rr     (rr),
        .wavsel (wavsel),
        .fnum   (fnum),
        .block  (block),
        .keyon  (keyon),
        .fb     (fb),
        .con    (con)
    );

    opl_timers #(
        .TIMER_A_DIV (TIMER_A_DIV),
        .TIMER_B_DIV (TIMER_B_DIV)
    ) u_timers (
        .clk    (clk),
        .rst    (rst),
        .cen    (cen),
        .tmr    (tmr_if.timer),
        .flag_a (flag_a),
        .flag_b (flag_b),
        .irq    (irq)
    );

endmodule

//--- tb/opl_assertions.sv
// Concurrent checks bound into the FM register front end top level.
// APB never stalls, and the slot counter steps through 0..17 only on cen.
`timescale 1ns/1ps

module opl_assertions
    import opl_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input logic  cen,
    input logic  pready,
    input slot_t slot
);
    // zero wait states
    a_pready_high: assert property (@(posedge clk) disable iff (rst) pready)
        else $error("pready dropped low");

    a_slot_range: assert property (@(posedge clk) disable iff (rst)
        slot < slot_t'(SLOT_COUNT))
        else $error("slot index %0d out of range", slot);

    // last slot wraps back to 0
    a_slot_step: assert property (@(posedge clk) disable iff (rst)
        cen |=> slot == (($past(slot) == slot_t'(SLOT_COUNT - 1)) ?
                         slot_t'(0) : slot_t'($past(slot) + 5'd1)))
        else $error("slot did not advance by one on cen");

    a_slot_hold: assert property (@(posedge clk) disable iff (rst)
        !cen |=> $stable(slot))
        else $error("slot changed without cen");

endmodule

bind opl_top opl_assertions u_assertions (
    .clk    (clk),
    .rst    (rst),
    .cen    (cen),
    .pready (pready),
    .slot   (slot)
);

//--- tb/opl_tb.sv
// Testbench for the FM register front end.
// Drives APB register writes, keeps a reference model of the operator and
// channel parameters and checks every slot readout after each cen step.
// Also exercises timers A/B and the status byte.
`timescale 1ns/1ps

module opl_tb
    import opl_pkg::*;
();
    localparam int OPL_TYPE     = 2;
    localparam int TIMER_A_DIV  = 2;
    localparam int TIMER_B_DIV  = 8;
    localparam int SEED         = 35184;
    localparam int CEN_DIV      = 4;
    localparam int SWEEP_CLKS   = SLOT_COUNT * CEN_DIV;
    localparam int N_OP_WRITES  = 60;
    localparam int N_MIX_WRITES = 200;
    localparam timer_val_t PRESET_A = 8'hF0;
    localparam timer_val_t PRESET_B = 8'hFC;
    localparam int EXTRA_CEN    = 40;
    // select plus data transfer, three clocks each
    localparam int WRITE_CLKS   = 6;
    localparam int TEST_CLKS    = 10 + (N_OP_WRITES + N_MIX_WRITES + 45) * WRITE_CLKS
                                  + 12 * SWEEP_CLKS
                                  + ((256 - PRESET_A) * TIMER_A_DIV + EXTRA_CEN) * CEN_DIV;
    localparam int MARGIN_CLKS  = 1000;

    typedef struct packed {
        slot_t      slot;
        logic [3:0] mul;
        tl_t        tl;
        logic [1:0] ksl;
        rate_t      ar;
        rate_t      dr;
        rate_t      sl;
        rate_t      rr;
        logic [1:0] wavsel;
        fnum_t      fnum;
        block_t     block;
        logic       keyon;
        logic [2:0] fb;
        logic       con;
    } slot_fields_t;

    logic       clk;
    logic       rst;
    logic       cen;
    logic       psel;
    logic       penable;
    logic       pwrite;
    logic [2:0] paddr;
    reg_data_t  pwdata;
    reg_data_t  prdata;
    logic       pready;
    logic       pslverr;
    slot_t      slot;
    logic [3:0] mul;
    tl_t        tl;
    logic [1:0] ksl;
    rate_t      ar;
    rate_t      dr;
    rate_t      sl;
    rate_t      rr;
    logic [1:0] wavsel;
    fnum_t      fnum;
    block_t     block;
    logic       keyon;
    logic [2:0] fb;
    logic       con;
    logic       irq;

    // reference model state
    logic [3:0]   ref_mul   [SLOT_COUNT];
    tl_t          ref_tl    [SLOT_COUNT];
    logic [1:0]   ref_ksl   [SLOT_COUNT];
    rate_t        ref_ar    [SLOT_COUNT];
    rate_t        ref_dr    [SLOT_COUNT];
    rate_t        ref_sl    [SLOT_COUNT];
    rate_t        ref_rr    [SLOT_COUNT];
    logic [1:0]   ref_wav   [SLOT_COUNT];
    fnum_t        ref_fnum  [CHAN_COUNT];
    block_t       ref_block [CHAN_COUNT];
    logic         ref_keyon [CHAN_COUNT];
    logic [2:0]   ref_fb    [CHAN_COUNT];
    logic         ref_con   [CHAN_COUNT];
    logic         ref_wave_mode;
    reg_addr_t    ref_sel;
    slot_t        ref_slot;
    logic         pend_valid;
    reg_addr_t    pend_reg;
    reg_data_t    pend_data;
    logic         check_due;
    slot_fields_t exp_fields;
    bit           verdict_printed;

    opl_top #(
        .OPL_TYPE    (OPL_TYPE),
        .TIMER_A_DIV (TIMER_A_DIV),
        .TIMER_B_DIV (TIMER_B_DIV)
    ) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // one cen pulse every CEN_DIV clocks once out of reset
    initial begin
        int div;
        div = 0;
        cen = 1'b0;
        forever begin
            @(posedge clk);
            if (rst) begin
                div = 0;
                cen <= 1'b0;
            end else begin
                div = (div + 1) % CEN_DIV;
                cen <= (div == 0);
            end
        end
    end

    initial begin
        repeat (TEST_CLKS + MARGIN_CLKS) @(posedge clk);
        $display("Watchdog expired after %0d clocks, the tests did not finish",
                 TEST_CLKS + MARGIN_CLKS);
        stop_on_error();
    end

    // run ended before the last test completed
    final begin
        if (!verdict_printed)
            $display("STATUS: FAIL");
    end

    task automatic stop_on_error();
        verdict_printed = 1'b1;
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic slot_matches(input string name, input slot_t got, input slot_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic rate_matches(input string name, input rate_t got, input rate_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic tl_matches(input string name, input tl_t got, input tl_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic fnum_matches(input string name, input fnum_t got, input fnum_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic block_matches(input string name, input block_t got, input block_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic status_matches(input string name, input reg_data_t got,
                                  input reg_data_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %02h, expected %02h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    // narrow untyped fields, zero extended
    task automatic field_matches(input string name, input logic [3:0] got,
                                 input logic [3:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic outputs_match(input slot_fields_t e);
        slot_matches("slot", slot, e.slot);
        field_matches("mul", mul, e.mul);
        tl_matches("tl", tl, e.tl);
        field_matches("ksl", 4'(ksl), 4'(e.ksl));
        rate_matches("ar", ar, e.ar);
        rate_matches("dr", dr, e.dr);
        rate_matches("sl", sl, e.sl);
        rate_matches("rr", rr, e.rr);
        field_matches("wavsel", 4'(wavsel), 4'(e.wavsel));
        fnum_matches("fnum", fnum, e.fnum);
        block_matches("block", block, e.block);
        field_matches("keyon", 4'(keyon), 4'(e.keyon));
        field_matches("fb", 4'(fb), 4'(e.fb));
        field_matches("con", 4'(con), 4'(e.con));
    endtask

    function automatic slot_fields_t expected_fields(input slot_t s);
        slot_fields_t e;
        int group;
        int sub;
        int ch;
        group = int'(s) / 6;
        sub   = int'(s) % 6;
        // operator 2 of a channel sits three slots after operator 1
        ch    = group * 3 + ((sub < 3) ? sub : sub - 3);
        e.slot   = s;
        e.mul    = ref_mul[s];
        e.tl     = ref_tl[s];
        e.ksl    = ref_ksl[s];
        e.ar     = ref_ar[s];
        e.dr     = ref_dr[s];
        e.sl     = ref_sl[s];
        e.rr     = ref_rr[s];
        e.wavsel = ref_wav[s];
        e.fnum   = ref_fnum[ch];
        e.block  = ref_block[ch];
        e.keyon  = ref_keyon[ch];
        e.fb     = ref_fb[ch];
        e.con    = ref_con[ch];
        return e;
    endfunction

    task automatic model_clear();
        for (int i = 0; i < SLOT_COUNT; i++) begin
            ref_mul[i] = '0;
            ref_tl[i]  = '0;
            ref_ksl[i] = '0;
            ref_ar[i]  = '0;
            ref_dr[i]  = '0;
            ref_sl[i]  = '0;
            ref_rr[i]  = '0;
            ref_wav[i] = '0;
        end
        for (int i = 0; i < CHAN_COUNT; i++) begin
            ref_fnum[i]  = '0;
            ref_block[i] = '0;
            ref_keyon[i] = 1'b0;
            ref_fb[i]    = '0;
            ref_con[i]   = 1'b0;
        end
        ref_wave_mode = 1'b0;
    endtask

    task automatic model_write(input reg_addr_t r, input reg_data_t d);
        int group;
        int sub;
        int s;
        int ch;
        group = int'(r[4:3]);
        sub   = int'(r[2:0]);
        s     = group * 6 + sub;
        ch    = int'(r[3:0]);
        if (r == REG_MODE)
            ref_wave_mode = d[5];
        if (sub < 6 && group < 3) begin
            case (r[7:5])
                3'd1: ref_mul[s] = d[3:0];
                3'd2: begin
                    ref_ksl[s] = d[7:6];
                    ref_tl[s]  = d[5:0];
                end
                3'd3: begin
                    ref_ar[s] = d[7:4];
                    ref_dr[s] = d[3:0];
                end
                3'd4: begin
                    ref_sl[s] = d[7:4];
                    ref_rr[s] = d[3:0];
                end
                3'd7: if (OPL_TYPE != 1 && ref_wave_mode) ref_wav[s] = d[1:0];
                default: ;
            endcase
        end
        if (ch < CHAN_COUNT) begin
            case (r[7:4])
                4'hA: ref_fnum[ch][7:0] = d;
                4'hB: begin
                    ref_keyon[ch]     = d[5];
                    ref_block[ch]     = d[4:2];
                    ref_fnum[ch][9:8] = d[1:0];
                end
                4'hC: begin
                    ref_fb[ch]  = d[3:1];
                    ref_con[ch] = d[0];
                end
                default: ;
            endcase
        end
    endtask

    // data reaches storage one clock after the access, readout on cen
    always @(posedge clk) begin
        if (rst) begin
            model_clear();
            ref_sel    = '0;
            ref_slot   = '0;
            pend_valid = 1'b0;
            check_due  = 1'b0;
        end else begin
            if (cen) begin
                ref_slot   = (ref_slot == slot_t'(SLOT_COUNT - 1)) ? '0 : ref_slot + 5'd1;
                exp_fields = expected_fields(ref_slot);
                check_due  = 1'b1;
            end
            if (pend_valid)
                model_write(pend_reg, pend_data);
            pend_valid = psel && penable && pwrite && paddr[2];
            pend_reg   = ref_sel;
            pend_data  = pwdata;
            if (psel && penable && pwrite && !paddr[2])
                ref_sel = pwdata;
        end
    end

    always @(negedge clk) begin
        if (check_due) begin
            check_due = 1'b0;
            outputs_match(exp_fields);
        end
    end

    task automatic write_port(input logic [2:0] addr, input reg_data_t data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        while (!pready)
            @(posedge clk);
        field_matches("pslverr", 4'(pslverr), 4'd0);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic read_status(output reg_data_t v);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= 3'd4;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        while (!pready)
            @(posedge clk);
        v = prdata;
        field_matches("pslverr", 4'(pslverr), 4'd0);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic select_and_write(input reg_addr_t r, input reg_data_t d);
        write_port(3'd0, r);
        write_port(3'd4, d);
    endtask

    task automatic wait_cen(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(posedge clk);
            if (cen)
                seen++;
        end
    endtask

    task automatic wait_slot(input slot_t s);
        @(negedge clk);
        while (slot != s)
            @(negedge clk);
    endtask

    // offsets 0..31, so sub 6/7 and group 3 show up too
    function automatic reg_addr_t random_op_reg();
        reg_addr_t bases [5] = '{8'h20, 8'h40, 8'h60, 8'h80, 8'hE0};
        return bases[$urandom_range(0, 4)] | reg_addr_t'($urandom_range(0, 31));
    endfunction

    function automatic reg_addr_t random_chan_reg();
        reg_addr_t bases [3] = '{8'hA0, 8'hB0, 8'hC0};
        return bases[$urandom_range(0, 2)] | reg_addr_t'($urandom_range(0, 9));
    endfunction

    initial begin
        reg_data_t status;
        reg_addr_t r;
        int        needed;
        int        seen;
        rst         = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        void'($urandom(SEED));
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // state right after reset
        @(negedge clk);
        outputs_match('0);
        field_matches("irq", 4'(irq), 4'd0);
        read_status(status);
        status_matches("status", status, 8'h00);

        // random operator writes
        for (int i = 0; i < N_OP_WRITES; i++)
            select_and_write(random_op_reg(), reg_data_t'($urandom));
        wait_cen(2 * SLOT_COUNT);

        // every channel, then two out of range
        for (int ch = 0; ch < CHAN_COUNT; ch++) begin
            select_and_write(reg_addr_t'(8'hA0 + ch), reg_data_t'($urandom));
            select_and_write(reg_addr_t'(8'hB0 + ch), reg_data_t'($urandom));
            select_and_write(reg_addr_t'(8'hC0 + ch), reg_data_t'($urandom));
        end
        select_and_write(8'hA9, 8'hFF);
        select_and_write(8'hCF, 8'hFF);
        wait_cen(2 * SLOT_COUNT);

        // waveform select ignored with mode bit 5 clear
        select_and_write(8'hE0, 8'h03);
        wait_cen(SLOT_COUNT);
        wait_slot(slot_t'(0));
        field_matches("wavsel", 4'(wavsel), 4'd0);
        select_and_write(REG_MODE, 8'h20);
        select_and_write(8'hE0, 8'h02);
        wait_cen(SLOT_COUNT);
        wait_slot(slot_t'(0));
        field_matches("wavsel", 4'(wavsel), (OPL_TYPE == 1) ? 4'd0 : 4'd2);

        // timer A runs, timer B runs masked
        select_and_write(REG_CLKA, PRESET_A);
        select_and_write(REG_CLKB, PRESET_B);
        select_and_write(REG_TIMER, 8'h23);
        needed = (256 - int'(PRESET_A)) * TIMER_A_DIV;
        seen   = 0;
        while (seen < needed + EXTRA_CEN) begin
            @(posedge clk);
            if (cen)
                seen++;
            @(negedge clk);
            field_matches("irq", 4'(irq), (seen >= needed) ? 4'd1 : 4'd0);
        end
        read_status(status);
        status_matches("status", status, 8'hC0);
        select_and_write(REG_TIMER, 8'h80);
        @(posedge clk);
        @(negedge clk);
        field_matches("irq", 4'(irq), 4'd0);
        read_status(status);
        status_matches("status", status, 8'h00);

        // mixed traffic over several sweeps
        for (int i = 0; i < N_MIX_WRITES; i++) begin
            case ($urandom_range(0, 3))
                0: r = random_chan_reg();
                1: r = ($urandom_range(0, 3) == 0) ? REG_GLOBAL : REG_MODE;
                default: r = random_op_reg();
            endcase
            select_and_write(r, reg_data_t'($urandom));
        end
        wait_cen(3 * SLOT_COUNT);
        @(negedge clk);

        verdict_printed = 1'b1;
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- list.f
common/opl_pkg.sv
common/opl_ifs.sv
mmr/opl_mmr_decode.sv
mmr/opl_slot_regs.sv
design/opl_timers.sv
design/opl_top.sv
tb/opl_assertions.sv
tb/opl_tb.sv

//--- Makefile
VERILATOR  = verilator
TOP        = opl_tb
LINT_TOP   = opl_top
FILELIST   = list.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = STATUS: PASS
VFLAGS     = --binary --assert -Wno-fatal -j 0
LINT_FLAGS = --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
